// File: design/kbd_axil_regs.sv
`timescale 1ns/1ns
`default_nettype none

module kbd_axil_regs (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    input  logic [7:0]  held_key0,
    input  logic [7:0]  held_key1,
    input  logic [1:0]  held_count,
    input  logic [7:0]  last_code,
    input  logic [15:0] event_count,
    input  logic        released,
    input  logic        combo,
    input  logic        frame_err_seen,
    output logic        clear_count,
    output logic        clear_err
);

    logic        aw_accept;
    logic        ar_accept;
    logic        wr_mapped;
    logic [31:0] status_word;
    logic [31:0] rd_word;
    logic        rd_mapped;

    // new address only when no response is pending
    assign aw_accept = awvalid & wvalid & ~awready & ~bvalid;
    assign ar_accept = arvalid & ~arready & ~rvalid;

    assign wr_mapped = (awaddr == kbd_regs_pkg::ADDR_STATUS) ||
                       (awaddr == kbd_regs_pkg::ADDR_LAST_CODE) ||
                       (awaddr == kbd_regs_pkg::ADDR_EVENT_COUNT) ||
                       (awaddr == kbd_regs_pkg::ADDR_HELD_KEYS);

    always_comb begin
        status_word = 32'd0;
        status_word[kbd_regs_pkg::STAT_COMBO]         = combo;
        status_word[kbd_regs_pkg::STAT_RELEASED]      = released;
        status_word[kbd_regs_pkg::STAT_HELD_LSB +: 2] = held_count;
        status_word[kbd_regs_pkg::STAT_FRAME_ERR]     = frame_err_seen;
    end

    always_comb begin
        rd_mapped = 1'b1;
        case (araddr)
            kbd_regs_pkg::ADDR_STATUS:      rd_word = status_word;
            kbd_regs_pkg::ADDR_LAST_CODE:   rd_word = {24'd0, last_code};
            kbd_regs_pkg::ADDR_EVENT_COUNT: rd_word = {16'd0, event_count};
            kbd_regs_pkg::ADDR_HELD_KEYS:   rd_word = {16'd0, held_key1, held_key0};
            default: begin
                rd_word   = 32'd0;  // unmapped reads as zero
                rd_mapped = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready     <= 1'b0;
            wready      <= 1'b0;
            bvalid      <= 1'b0;
            clear_count <= 1'b0;
            clear_err   <= 1'b0;
        end else begin
            awready     <= aw_accept;
            wready      <= aw_accept;
            clear_count <= 1'b0;
            clear_err   <= 1'b0;
            if (awready) begin  // aw and w complete on this edge
                bvalid      <= 1'b1;
                clear_count <= (awaddr == kbd_regs_pkg::ADDR_EVENT_COUNT);
                clear_err   <= (awaddr == kbd_regs_pkg::ADDR_STATUS);
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awready) begin
            bresp <= wr_mapped ? kbd_regs_pkg::RESP_OKAY : kbd_regs_pkg::RESP_SLVERR;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= ar_accept;
            if (arready) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // snapshot taken on the address handshake
    always_ff @(posedge clk) begin
        if (arready) begin
            rdata <= rd_word;
            rresp <= rd_mapped ? kbd_regs_pkg::RESP_OKAY : kbd_regs_pkg::RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

// File: design/kbd_regs_pkg.sv
`default_nettype none

package kbd_regs_pkg;

    // register map, byte addresses
    localparam logic [3:0] ADDR_STATUS      = 4'h0;
    localparam logic [3:0] ADDR_LAST_CODE   = 4'h4;
    localparam logic [3:0] ADDR_EVENT_COUNT = 4'h8;
    localparam logic [3:0] ADDR_HELD_KEYS   = 4'hC;

    // STATUS fields
    localparam int STAT_COMBO     = 0;
    localparam int STAT_RELEASED  = 1;
    localparam int STAT_HELD_LSB  = 2;  // two bits wide
    localparam int STAT_FRAME_ERR = 4;  // sticky until written

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

endpackage

`default_nettype wire

// File: design/key_track_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module key_track_fsm (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clear_count,
    input  logic        clear_err,
    ps2_byte_if.trk     byte_if,
    output logic [7:0]  held_key0,
    output logic [7:0]  held_key1,
    output logic [7:0]  last_code,
    output logic [1:0]  held_count,
    output logic [15:0] event_count,
    output logic        released,
    output logic        combo,
    output logic        frame_err_seen
);

    ps2_pkg::key_state_e state;
    ps2_pkg::key_state_e state_nxt;
    logic                break_pending;
    logic                pending_nxt;
    logic [7:0]          slot0_nxt;
    logic [7:0]          slot1_nxt;
    logic                rel_nxt;
    logic                bump;
    logic [7:0]          code;
    logic                hit0;
    logic                hit1;

    assign code = byte_if.byte_code;
    assign hit0 = (code != 8'h00) && (code == held_key0);  // empty slots hold zero
    assign hit1 = (code != 8'h00) && (code == held_key1);

    always_comb begin
        slot0_nxt   = held_key0;
        slot1_nxt   = held_key1;
        pending_nxt = break_pending;
        rel_nxt     = released;
        bump        = 1'b0;
        if (byte_if.byte_valid) begin
            if (code == ps2_pkg::BREAK_CODE) begin
                pending_nxt = 1'b1;
            end else if (break_pending) begin
                pending_nxt = 1'b0;
                if (hit0 || hit1) begin
                    if (hit0) begin
                        slot0_nxt = 8'h00;
                    end else begin
                        slot1_nxt = 8'h00;
                    end
                    bump    = 1'b1;
                    rel_nxt = 1'b1;
                end
            end else if ((code != 8'h00) && !hit0 && !hit1 &&
                         (state != ps2_pkg::KEYS_TWO)) begin
                if (held_key0 == 8'h00) begin  // lowest free slot first
                    slot0_nxt = code;
                end else begin
                    slot1_nxt = code;
                end
                bump    = 1'b1;
                rel_nxt = 1'b0;
            end
        end
    end

    always_comb begin
        case ({slot1_nxt != 8'h00, slot0_nxt != 8'h00})
            2'b00:   state_nxt = ps2_pkg::KEYS_NONE;
            2'b11:   state_nxt = ps2_pkg::KEYS_TWO;
            default: state_nxt = ps2_pkg::KEYS_ONE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= ps2_pkg::KEYS_NONE;
            held_key0      <= 8'h00;
            held_key1      <= 8'h00;
            last_code      <= 8'h00;
            break_pending  <= 1'b0;
            released       <= 1'b0;
            event_count    <= 16'd0;
            frame_err_seen <= 1'b0;
        end else begin
            state         <= state_nxt;
            held_key0     <= slot0_nxt;
            held_key1     <= slot1_nxt;
            break_pending <= pending_nxt;
            released      <= rel_nxt;
            if (byte_if.byte_valid) begin
                last_code <= code;
            end
            if (clear_count) begin
                event_count <= 16'd0;
            end else if (bump) begin
                event_count <= event_count + 16'd1;
            end
            if (byte_if.err_valid && byte_if.frame_err) begin
                frame_err_seen <= 1'b1;  // a new error beats a clear
            end else if (clear_err) begin
                frame_err_seen <= 1'b0;
            end
        end
    end

    assign held_count = state;  // enum value is the key count
    assign combo = (held_key0 == ps2_pkg::LSHIFT_CODE) || (held_key0 == ps2_pkg::LCTRL_CODE) ||
                   (held_key1 == ps2_pkg::LSHIFT_CODE) || (held_key1 == ps2_pkg::LCTRL_CODE);

endmodule

`default_nettype wire

// File: design/ps2_bit_timer.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_bit_timer (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_clk,
    output logic       bit_strobe,
    output logic       frame_done,
    output logic [3:0] bit_index
);

    logic [2:0]         clk_sync;  // [0] meets the pin
    logic [3:0]         bit_cnt;
    ps2_pkg::idle_cnt_t idle_cnt;
    logic               mid_frame;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync <= 3'b111;  // bus idles high
        end else begin
            clk_sync <= {clk_sync[1:0], ps2_clk};
        end
    end

    // falling edge seen between the last two stages
    assign bit_strobe = clk_sync[2] & ~clk_sync[1];
    assign frame_done = bit_strobe && (bit_cnt == ps2_pkg::LAST_BIT_INDEX);
    assign bit_index  = bit_cnt;
    assign mid_frame  = (bit_cnt != 4'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt  <= 4'd0;
            idle_cnt <= '0;
        end else if (bit_strobe) begin
            idle_cnt <= '0;
            if (frame_done) begin
                bit_cnt <= 4'd0;  // ready for the next start bit
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else if (mid_frame) begin
            if (idle_cnt == ps2_pkg::IDLE_LAST) begin
                // keyboard stopped mid-frame, drop what we have
                bit_cnt  <= 4'd0;
                idle_cnt <= '0;
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end else begin
            idle_cnt <= '0;
        end
    end

endmodule

`default_nettype wire

// File: design/ps2_byte_if.sv
`timescale 1ns/1ns
`default_nettype none

// byte hand-off from the frame receiver to the key tracker, no back-pressure
interface ps2_byte_if;

    logic       byte_valid;  // one-cycle pulse, good frame
    logic [7:0] byte_code;
    logic       frame_err;   // status of the last frame
    logic       err_valid;   // one-cycle pulse, bad frame

    modport rx (
        output byte_valid,
        output byte_code,
        output frame_err,
        output err_valid
    );

    modport trk (
        input byte_valid,
        input byte_code,
        input frame_err,
        input err_valid
    );

endinterface

`default_nettype wire

// File: design/ps2_frame_rx.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_frame_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ps2_data,
    input  logic       bit_strobe,
    input  logic       frame_done,
    input  logic [3:0] bit_index,
    ps2_byte_if.rx     byte_if
);

    logic [1:0] data_sync;   // lines up with the clock edge detector
    logic [9:0] frame_buf;   // start, data, parity; stop is checked live
    logic       start_ok;
    logic       stop_ok;
    logic       parity_ok;
    logic       frame_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_sync <= 2'b11;
        end else begin
            data_sync <= {data_sync[0], ps2_data};
        end
    end

    always_ff @(posedge clk) begin
        if (bit_strobe && !frame_done) begin
            frame_buf[bit_index] <= data_sync[1];
        end
    end

    assign start_ok  = ~frame_buf[0];
    assign stop_ok   = data_sync[1];     // bit 10 arrives with frame_done
    assign parity_ok = ^frame_buf[9:1];  // odd over data and parity
    assign frame_ok  = start_ok & stop_ok & parity_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_if.byte_valid <= 1'b0;
            byte_if.err_valid  <= 1'b0;
            byte_if.frame_err  <= 1'b0;
        end else begin
            byte_if.byte_valid <= frame_done & frame_ok;
            byte_if.err_valid  <= frame_done & ~frame_ok;
            if (frame_done) begin
                byte_if.frame_err <= ~frame_ok;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_done) begin
            byte_if.byte_code <= frame_buf[8:1];
        end
    end

endmodule

`default_nettype wire

// File: design/ps2_kbd_top.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_kbd_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ps2_clk,
    input  logic        ps2_data,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    logic        bit_strobe;
    logic        frame_done;
    logic [3:0]  bit_index;
    logic [7:0]  held_key0;
    logic [7:0]  held_key1;
    logic [7:0]  last_code;
    logic [1:0]  held_count;
    logic [15:0] event_count;
    logic        released;
    logic        combo;
    logic        frame_err_seen;
    logic        clear_count;
    logic        clear_err;

    ps2_byte_if byte_bus ();

    ps2_bit_timer u_bit_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .bit_strobe (bit_strobe),
        .frame_done (frame_done),
        .bit_index  (bit_index)
    );

    ps2_frame_rx u_frame_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .ps2_data   (ps2_data),
        .bit_strobe (bit_strobe),
        .frame_done (frame_done),
        .bit_index  (bit_index),
        .byte_if    (byte_bus.rx)
    );

    key_track_fsm u_tracker (
        .clk            (clk),
        .rst_n          (rst_n),
        .clear_count    (clear_count),
        .clear_err      (clear_err),
        .byte_if        (byte_bus.trk),
        .held_key0      (held_key0),
        .held_key1      (held_key1),
        .last_code      (last_code),
        .held_count     (held_count),
        .event_count    (event_count),
        .released       (released),
        .combo          (combo),
        .frame_err_seen (frame_err_seen)
    );

    kbd_axil_regs u_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .awaddr         (awaddr),
        .awvalid        (awvalid),
        .awready        (awready),
        .wdata          (wdata),
        .wvalid         (wvalid),
        .wready         (wready),
        .bresp          (bresp),
        .bvalid         (bvalid),
        .bready         (bready),
        .araddr         (araddr),
        .arvalid        (arvalid),
        .arready        (arready),
        .rdata          (rdata),
        .rresp          (rresp),
        .rvalid         (rvalid),
        .rready         (rready),
        .held_key0      (held_key0),
        .held_key1      (held_key1),
        .held_count     (held_count),
        .last_code      (last_code),
        .event_count    (event_count),
        .released       (released),
        .combo          (combo),
        .frame_err_seen (frame_err_seen),
        .clear_count    (clear_count),
        .clear_err      (clear_err)
    );

endmodule

`default_nettype wire

// File: design/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

    // frame layout: start, 8 data bits lsb first, odd parity, stop
    localparam int FRAME_BITS = 11;
    localparam logic [3:0] LAST_BIT_INDEX = 4'(FRAME_BITS - 1);

    // keyboard scan codes, set 2
    localparam logic [7:0] BREAK_CODE  = 8'hF0;  // precedes a release code
    localparam logic [7:0] LSHIFT_CODE = 8'h12;
    localparam logic [7:0] LCTRL_CODE  = 8'h14;

    // system clocks without a falling edge before a partial frame is dropped
    localparam int IDLE_TIMEOUT_CYCLES = 2000;
    localparam int IDLE_CNT_W = $clog2(IDLE_TIMEOUT_CYCLES);

    typedef logic [IDLE_CNT_W-1:0] idle_cnt_t;

    localparam idle_cnt_t IDLE_LAST = idle_cnt_t'(IDLE_TIMEOUT_CYCLES - 1);

    // number of keys held at the same time
    typedef enum logic [1:0] {
        KEYS_NONE = 2'd0,
        KEYS_ONE  = 2'd1,
        KEYS_TWO  = 2'd2
    } key_state_e;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the PS/2 keyboard testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns -f sources.f \
    --top-module ps2_kbd_tb -o ps2_kbd_sim &&
./obj_dir/ps2_kbd_sim | tee /dev/stderr | grep -q "TB PASSED" &&
echo "simulation result: pass" ||
{ echo "simulation result: fail"; exit 1; }

// File: sources.f
design/ps2_pkg.sv
design/kbd_regs_pkg.sv
design/ps2_byte_if.sv
design/ps2_bit_timer.sv
design/ps2_frame_rx.sv
design/key_track_fsm.sv
design/kbd_axil_regs.sv
design/ps2_kbd_top.sv
verif/ps2_clk_gen.sv
verif/ps2_kbd_props.sv
verif/ps2_kbd_tb.sv

// File: verif/ps2_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 5;  // 10 ns clock

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;  // released away from the active edge
    end

endmodule

`default_nettype wire

// File: verif/ps2_kbd_props.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_kbd_props (
    input logic       clk,
    input logic       rst_n,
    input logic       rvalid,
    input logic       rready,
    input logic       bvalid,
    input logic       bready,
    input logic       byte_valid,
    input logic       err_valid,
    input logic [3:0] bit_index
);

    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    // a frame is either good or bad, never both
    byte_err_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(byte_valid && err_valid))
        else $error("byte_valid and err_valid high together");

    bit_index_range: assert property (@(posedge clk) disable iff (!rst_n)
        bit_index <= ps2_pkg::LAST_BIT_INDEX)
        else $error("bit_index ran past the frame length");

endmodule

bind ps2_kbd_top ps2_kbd_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .rvalid     (rvalid),
    .rready     (rready),
    .bvalid     (bvalid),
    .bready     (bready),
    .byte_valid (byte_bus.byte_valid),
    .err_valid  (byte_bus.err_valid),
    .bit_index  (bit_index)
);

`default_nettype wire

// File: verif/ps2_kbd_tb.sv
`timescale 1ns/1ns
`default_nettype none

module ps2_kbd_tb;

    localparam int BIT_CLKS        = 40;   // system clocks per PS/2 bit
    localparam int DIRECTED_ROUNDS = 29;   // frames plus compare-only rounds
    localparam int RAND_EVENTS     = 24;   // each is one or two frames
    localparam int ROUND_CLKS      = ps2_pkg::FRAME_BITS * BIT_CLKS + 120;
    localparam int CYCLE_LIMIT     = (DIRECTED_ROUNDS + 2 * RAND_EVENTS) * ROUND_CLKS + 2000;

    typedef struct packed {
        logic [7:0]  key0;
        logic [7:0]  key1;
        logic [7:0]  last;
        logic [15:0] count;
        logic        released;
        logic        pending;   // break code seen, waiting for the key
        logic        err;
    } model_t;

    logic        clk;
    logic        rst_n;
    logic        ps2_clk;
    logic        ps2_data;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    model_t      exp_state;
    integer      seed;
    int          cycle_count = 0;
    int          ev;
    logic [31:0] rnd;
    logic [7:0]  code;
    event        frame_sent;
    event        regs_checked;

    ps2_clk_gen clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ps2_kbd_top UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready)
    );

    // tracker rules applied to one good byte
    function automatic model_t track_ref(input model_t m, input logic [7:0] c);
        model_t n;
        n = m;
        n.last = c;
        if (c == ps2_pkg::BREAK_CODE) begin
            n.pending = 1'b1;
        end else if (m.pending) begin
            n.pending = 1'b0;
            if (c != 8'h00 && c == m.key0) begin
                n.key0     = 8'h00;
                n.count    = m.count + 16'd1;
                n.released = 1'b1;
            end else if (c != 8'h00 && c == m.key1) begin
                n.key1     = 8'h00;
                n.count    = m.count + 16'd1;
                n.released = 1'b1;
            end
        end else if (c != 8'h00 && c != m.key0 && c != m.key1 &&
                     (m.key0 == 8'h00 || m.key1 == 8'h00)) begin
            if (m.key0 == 8'h00) begin
                n.key0 = c;
            end else begin
                n.key1 = c;
            end
            n.count    = m.count + 16'd1;
            n.released = 1'b0;
        end
        return n;
    endfunction

    function automatic logic [31:0] expected_status(input model_t m);
        logic [31:0] w;
        logic [1:0]  held;
        w    = 32'd0;
        held = {1'b0, m.key0 != 8'h00} + {1'b0, m.key1 != 8'h00};
        w[kbd_regs_pkg::STAT_COMBO] = (m.key0 == ps2_pkg::LSHIFT_CODE) ||
                                      (m.key0 == ps2_pkg::LCTRL_CODE) ||
                                      (m.key1 == ps2_pkg::LSHIFT_CODE) ||
                                      (m.key1 == ps2_pkg::LCTRL_CODE);
        w[kbd_regs_pkg::STAT_RELEASED]      = m.released;
        w[kbd_regs_pkg::STAT_HELD_LSB +: 2] = held;
        w[kbd_regs_pkg::STAT_FRAME_ERR]     = m.err;
        return w;
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s read %h, expected %h", $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // start, 8 data bits lsb first, parity, stop
    task automatic send_frame(input logic [7:0] c, input logic good_parity);
        logic [10:0] bits;
        logic        par;
        par  = good_parity ? ~^c : ^c;
        bits = {1'b1, par, c, 1'b0};
        @(negedge clk);
        for (int i = 0; i < ps2_pkg::FRAME_BITS; i++) begin
            ps2_data = bits[i];
            repeat (BIT_CLKS / 2) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (BIT_CLKS / 2) @(negedge clk);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b0;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(negedge clk);  // address taken on the edge before
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        @(negedge clk);  // response waits one cycle for rready
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        @(negedge clk);  // response waits one cycle for bready
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic read_expect(input logic [3:0] addr, input logic [31:0] exp_data,
                               input logic [1:0] exp_resp, input string what);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, data, resp);
        check_value(what, data, exp_data);
        check_value({what, " rresp"}, {30'd0, resp}, {30'd0, exp_resp});
    endtask

    task automatic write_expect(input logic [3:0] addr, input logic [1:0] exp_resp);
        logic [1:0] resp;
        axi_write(addr, 32'hFFFF_FFFF, resp);  // data is ignored by the slave
        check_value("bresp", {30'd0, resp}, {30'd0, exp_resp});
    endtask

    task automatic run_compare();
        -> frame_sent;
        @(regs_checked);
    endtask

    task automatic send_key_byte(input logic [7:0] c);
        send_frame(c, 1'b1);
        exp_state = track_ref(exp_state, c);
        run_compare();
    endtask

    task automatic send_release(input logic [7:0] c);
        send_key_byte(ps2_pkg::BREAK_CODE);
        send_key_byte(c);
    endtask

    task automatic pick_code(output logic [7:0] c);
        logic [31:0] r;
        r = $random(seed);
        c = r[15:8];
        while (c == 8'h00 || c == ps2_pkg::BREAK_CODE || c == 8'hE0) begin
            r = $random(seed);
            c = r[15:8];
        end
    endtask

    // register readback against the model after every frame
    initial begin
        araddr  = 4'h0;
        arvalid = 1'b0;
        rready  = 1'b0;
        forever begin
            @(frame_sent);
            read_expect(kbd_regs_pkg::ADDR_STATUS, expected_status(exp_state),
                        kbd_regs_pkg::RESP_OKAY, "STATUS");
            read_expect(kbd_regs_pkg::ADDR_LAST_CODE, {24'd0, exp_state.last},
                        kbd_regs_pkg::RESP_OKAY, "LAST_CODE");
            read_expect(kbd_regs_pkg::ADDR_EVENT_COUNT, {16'd0, exp_state.count},
                        kbd_regs_pkg::RESP_OKAY, "EVENT_COUNT");
            read_expect(kbd_regs_pkg::ADDR_HELD_KEYS, {16'd0, exp_state.key1, exp_state.key0},
                        kbd_regs_pkg::RESP_OKAY, "HELD_KEYS");
            read_expect(4'h2, 32'd0, kbd_regs_pkg::RESP_SLVERR, "unmapped 0x2");
            -> regs_checked;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not end within %0d clock cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    initial begin
        ps2_clk   = 1'b1;  // bus idles high
        ps2_data  = 1'b1;
        awaddr    = 4'h0;
        awvalid   = 1'b0;
        wdata     = 32'd0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        exp_state = '0;
        seed      = 32'h1165_57fa;
        wait (rst_n === 1'b1);

        // one key, two keys, then ignored presses
        send_key_byte(8'h1C);
        send_key_byte(8'h32);
        send_key_byte(8'h21);  // both slots busy
        send_key_byte(8'h1C);  // repeat of a held key

        // releases, held and not held
        send_release(8'h1C);
        send_release(8'h2B);
        send_key_byte(8'h21);  // lands in slot 0 again
        send_release(8'h32);
        send_release(8'h21);

        // modifier combo
        send_key_byte(ps2_pkg::LSHIFT_CODE);
        send_release(ps2_pkg::LSHIFT_CODE);
        send_key_byte(ps2_pkg::LCTRL_CODE);
        send_key_byte(8'h1C);
        send_release(ps2_pkg::LCTRL_CODE);
        send_release(8'h1C);

        // bad parity, then clear the sticky flag
        send_key_byte(8'h1B);
        send_frame(8'h2D, 1'b0);
        exp_state.err = 1'b1;
        run_compare();
        write_expect(kbd_regs_pkg::ADDR_STATUS, kbd_regs_pkg::RESP_OKAY);
        exp_state.err = 1'b0;
        run_compare();
        send_release(8'h1B);

        // count clear, harmless write, unmapped write
        write_expect(kbd_regs_pkg::ADDR_EVENT_COUNT, kbd_regs_pkg::RESP_OKAY);
        exp_state.count = 16'd0;
        run_compare();
        write_expect(kbd_regs_pkg::ADDR_LAST_CODE, kbd_regs_pkg::RESP_OKAY);
        run_compare();
        write_expect(4'h6, kbd_regs_pkg::RESP_SLVERR);

        // random make and break traffic
        for (ev = 0; ev < RAND_EVENTS; ev++) begin
            rnd = $random(seed);
            case (rnd[1:0])
                2'd0: begin
                    if (exp_state.key0 != 8'h00) begin
                        send_release(exp_state.key0);
                    end else if (exp_state.key1 != 8'h00) begin
                        send_release(exp_state.key1);
                    end else begin
                        pick_code(code);
                        send_key_byte(code);
                    end
                end
                2'd1: begin
                    send_key_byte(rnd[2] ? ps2_pkg::LCTRL_CODE : ps2_pkg::LSHIFT_CODE);
                end
                2'd2: begin
                    pick_code(code);
                    send_release(code);  // mostly a key that is not held
                end
                default: begin
                    pick_code(code);
                    send_key_byte(code);
                end
            endcase
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
